// ==== vlog.f ====
source/nes_input_pkg.sv
source/button_debounce.sv
source/joypad_shifter.sv
source/joypad_bus_port.sv
source/nes_input_top.sv
verification/tb_nes_input.sv

// ==== Bender.yml ====
package:
  name: nes_input

sources:
  - source/nes_input_pkg.sv
  - source/button_debounce.sv
  - source/joypad_shifter.sv
  - source/joypad_bus_port.sv
  - source/nes_input_top.sv
  - target: test
    files:
      - verification/tb_nes_input.sv

// ==== verification/tb_nes_input.sv ====
// Testbench for the NES controller subsystem
// Directed tests of latch, serial reads, strobe hold, port independence and debounce
`default_nettype none

module tb_nes_input;
	import nes_input_pkg::*;

	localparam int CLK_HALF = 10;
	localparam int RESET_CYCLES = 5;
	localparam int SETTLE_CYCLES = 12;
	localparam int NUM_PATTERNS = 50;
	localparam logic [31:0] SEED = 32'h53839fe0;
	// Each pattern: pin set, settle, two writes and twenty reads at two cycles each
	localparam int PATTERN_CYCLES = 1 + SETTLE_CYCLES + 2 * 2 + 20 * 2;
	// Reset, readback after reset and the three short tests
	localparam int OTHER_CYCLES = 200;
	localparam int TIMEOUT_CYCLES = 2 * (NUM_PATTERNS * PATTERN_CYCLES + OTHER_CYCLES);

	logic       clk;
	logic       rst;
	cpu_bus_t   cpu;
	buttons_t   pad0_pins;
	buttons_t   pad1_pins;
	logic [7:0] rdata;

	logic [31:0] rng_state;
	int          pass_count = 0;
	int          fail_count = 0;
	int          cycle_count = 0;

	nes_input_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.cpu       (cpu),
		.pad0_pins (pad0_pins),
		.pad1_pins (pad1_pins),
		.rdata     (rdata)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Byte a port returns on its n-th read after the latch
	// Buttons A first, then ones once all eight are out
	function automatic logic [7:0] serial_byte(input logic [7:0] pat, input int index);
		if (index < BUTTON_COUNT) begin
			return {7'b0, pat[index]};
		end
		return 8'h01;
	endfunction

	task automatic next_pattern(output logic [7:0] pat);
		rng_state = xorshift32(rng_state);
		pat = rng_state[15:8];
	endtask

	task automatic check_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %h got %h", name, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic set_pads(input logic [7:0] pat0, input logic [7:0] pat1);
		@(posedge clk);
		pad0_pins <= pat0;
		pad1_pins <= pat1;
	endtask

	// Write cycle, then the bus goes idle
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu.addr     <= addr;
		cpu.read_en  <= 1'b0;
		cpu.write_en <= 1'b1;
		cpu.wdata    <= data;
		@(posedge clk);
		cpu.write_en <= 1'b0;
	endtask

	// Read cycle, rdata sampled mid cycle after the capturing edge
	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk);
		cpu.addr     <= addr;
		cpu.read_en  <= 1'b1;
		cpu.write_en <= 1'b0;
		cpu.wdata    <= 8'h00;
		@(posedge clk);
		cpu.read_en <= 1'b0;
		@(negedge clk);
		data = rdata;
	endtask

	// Strobe pulse that loads both shifters
	task automatic latch_buttons();
		cpu_write(JOY0_ADDR, 8'h01);
		cpu_write(JOY0_ADDR, 8'h00);
	endtask

	task automatic reset_readback();
		logic [7:0] data;
		int errors_before;
		errors_before = fail_count;
		// Shifters come out of reset full of ones
		for (int k = 0; k < 2; k++) begin
			cpu_read(JOY0_ADDR, data);
			check_value("rdata port 0", 8'h01, data);
			cpu_read(JOY1_ADDR, data);
			check_value("rdata port 1", 8'h01, data);
		end
		$display("reset_readback done, %0d errors", fail_count - errors_before);
	endtask

	task automatic latch_and_shift();
		logic [7:0] pat0;
		logic [7:0] pat1;
		logic [7:0] data;
		int errors_before;
		errors_before = fail_count;
		for (int p = 0; p < NUM_PATTERNS; p++) begin
			next_pattern(pat0);
			next_pattern(pat1);
			set_pads(pat0, pat1);
			wait_cycles(SETTLE_CYCLES);
			latch_buttons();
			// Eight button bits, then two reads past the end
			for (int k = 0; k < 10; k++) begin
				cpu_read(JOY0_ADDR, data);
				check_value("rdata port 0", serial_byte(pat0, k), data);
			end
			for (int k = 0; k < 10; k++) begin
				cpu_read(JOY1_ADDR, data);
				check_value("rdata port 1", serial_byte(pat1, k), data);
			end
		end
		$display("latch_and_shift done, %0d errors", fail_count - errors_before);
	endtask

	task automatic strobe_held();
		logic [7:0] pat0;
		logic [7:0] pat1;
		logic [7:0] data;
		int errors_before;
		errors_before = fail_count;
		next_pattern(pat0);
		next_pattern(pat1);
		set_pads(pat0, pat1);
		wait_cycles(SETTLE_CYCLES);
		cpu_write(JOY0_ADDR, 8'h01);
		// Reads keep returning A while the strobe stays up
		for (int k = 0; k < 3; k++) begin
			cpu_read(JOY0_ADDR, data);
			check_value("rdata port 0 strobe", {7'b0, pat0[0]}, data);
		end
		@(posedge clk);
		pad0_pins.a <= ~pat0[0];
		wait_cycles(SETTLE_CYCLES);
		for (int k = 0; k < 3; k++) begin
			cpu_read(JOY0_ADDR, data);
			check_value("rdata port 0 strobe", {7'b0, ~pat0[0]}, data);
		end
		cpu_write(JOY0_ADDR, 8'h00);
		$display("strobe_held done, %0d errors", fail_count - errors_before);
	endtask

	task automatic port_independence();
		logic [7:0] pat0;
		logic [7:0] pat1;
		logic [7:0] data;
		int errors_before;
		errors_before = fail_count;
		next_pattern(pat0);
		next_pattern(pat1);
		set_pads(pat0, pat1);
		wait_cycles(SETTLE_CYCLES);
		latch_buttons();
		for (int k = 0; k < 3; k++) begin
			cpu_read(JOY0_ADDR, data);
			check_value("rdata port 0", serial_byte(pat0, k), data);
		end
		// Port 1 has not moved yet
		cpu_read(JOY1_ADDR, data);
		check_value("rdata port 1", serial_byte(pat1, 0), data);
		cpu_read(JOY0_ADDR, data);
		check_value("rdata port 0", serial_byte(pat0, 3), data);
		cpu_read(JOY1_ADDR, data);
		check_value("rdata port 1", serial_byte(pat1, 1), data);
		$display("port_independence done, %0d errors", fail_count - errors_before);
	endtask

	task automatic debounce_filter();
		logic [7:0] data;
		int errors_before;
		errors_before = fail_count;
		set_pads(8'h00, 8'h00);
		wait_cycles(SETTLE_CYCLES);
		// Two cycle glitch on A, shorter than the hold time
		@(posedge clk);
		pad0_pins.a <= 1'b1;
		wait_cycles(2);
		pad0_pins.a <= 1'b0;
		latch_buttons();
		cpu_read(JOY0_ADDR, data);
		check_value("rdata port 0 glitch", 8'h00, data);
		wait_cycles(SETTLE_CYCLES);
		latch_buttons();
		cpu_read(JOY0_ADDR, data);
		check_value("rdata port 0 glitch", 8'h00, data);
		// Held press gets through
		@(posedge clk);
		pad0_pins.a <= 1'b1;
		wait_cycles(SETTLE_CYCLES);
		latch_buttons();
		cpu_read(JOY0_ADDR, data);
		check_value("rdata port 0 held", 8'h01, data);
		cpu_read(JOY0_ADDR, data);
		check_value("rdata port 0 held", 8'h00, data);
		$display("debounce_filter done, %0d errors", fail_count - errors_before);
	endtask

	initial begin
		rst = 1'b0;
		cpu = '0;
		pad0_pins = '0;
		pad1_pins = '0;
		rng_state = SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
		wait_cycles(2);

		reset_readback();
		latch_and_shift();
		strobe_held();
		port_independence();
		debounce_filter();

		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/nes_input_top.sv ====
// NES controller subsystem top level
// Bus port feeding two debounced controller shifters
`default_nettype none

module nes_input_top (
	input  wire                          clk,
	input  wire                          rst,
	input  wire nes_input_pkg::cpu_bus_t cpu,
	input  wire nes_input_pkg::buttons_t pad0_pins,
	input  wire nes_input_pkg::buttons_t pad1_pins,
	output logic [7:0]                   rdata
);
	import nes_input_pkg::*;

	// Debounced buttons per port
	buttons_t pad0_btn;
	buttons_t pad1_btn;

	// Bus port to shifters
	logic strobe;
	logic shift0;
	logic shift1;

	// Shifters back to bus port
	logic ser_bit0;
	logic ser_bit1;

	joypad_bus_port i_bus_port (
		.clk      (clk),
		.rst      (rst),
		.cpu      (cpu),
		.ser_bit0 (ser_bit0),
		.ser_bit1 (ser_bit1),
		.strobe   (strobe),
		.shift0   (shift0),
		.shift1   (shift1),
		.rdata    (rdata)
	);

	// Port 0 at 4016h
	button_debounce i_debounce0 (
		.clk     (clk),
		.rst     (rst),
		.pins    (pad0_pins),
		.buttons (pad0_btn)
	);

	joypad_shifter i_shifter0 (
		.clk     (clk),
		.rst     (rst),
		.strobe  (strobe),
		.shift   (shift0),
		.buttons (pad0_btn),
		.ser_bit (ser_bit0)
	);

	// Port 1 at 4017h, shares the strobe
	button_debounce i_debounce1 (
		.clk     (clk),
		.rst     (rst),
		.pins    (pad1_pins),
		.buttons (pad1_btn)
	);

	joypad_shifter i_shifter1 (
		.clk     (clk),
		.rst     (rst),
		.strobe  (strobe),
		.shift   (shift1),
		.buttons (pad1_btn),
		.ser_bit (ser_bit1)
	);

endmodule

`default_nettype wire

// ==== source/joypad_bus_port.sv ====
// CPU bus port for the two controller registers
// Decodes 4016h and 4017h, keeps the strobe latch and returns the read byte
`default_nettype none

module joypad_bus_port (
	input  wire                          clk,
	input  wire                          rst,
	input  wire nes_input_pkg::cpu_bus_t cpu,
	input  wire                          ser_bit0,
	input  wire                          ser_bit1,
	output logic                         strobe,
	output logic                         shift0,
	output logic                         shift1,
	output logic [7:0]                   rdata
);
	import nes_input_pkg::*;

	// Address decode
	logic hit0;
	logic hit1;

	// Access decode
	logic rd0;
	logic rd1;
	logic wr_strobe;

	assign hit0 = (cpu.addr == JOY0_ADDR);
	assign hit1 = (cpu.addr == JOY1_ADDR);

	assign rd0       = cpu.read_en && hit0;
	assign rd1       = cpu.read_en && hit1;
	// Only 4016h is writable and it carries the strobe for both ports
	assign wr_strobe = cpu.write_en && hit0;

	// Shift pulses in the same cycle as the read
	// The shifter advances at the edge that captures rdata
	assign shift0 = rd0;
	assign shift1 = rd1;

	// Strobe latch from bit 0 of the written byte
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			strobe <= 1'b0;
		end else if (wr_strobe) begin
			strobe <= cpu.wdata[0];
		end
	end

	// Read byte with the serial bit in bit 0 and the upper bits zero
	// Holds until the next read of either port
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdata <= '0;
		end else if (rd0) begin
			rdata <= {7'b0, ser_bit0};
		end else if (rd1) begin
			rdata <= {7'b0, ser_bit1};
		end
	end

	// CPU never drives both enables at once
	a_no_rd_wr : assert property (
		@(posedge clk) disable iff (!rst)
		!(cpu.read_en && cpu.write_en)
	);

	// One port advances per read
	a_one_shift : assert property (
		@(posedge clk) disable iff (!rst)
		!(shift0 && shift1)
	);

endmodule

`default_nettype wire

// ==== source/joypad_shifter.sv ====
// Controller shift register for one port
// Reloads the buttons while strobe is high and shifts one bit per CPU read
`default_nettype none

module joypad_shifter (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          strobe,
	input  wire                          shift,
	input  wire nes_input_pkg::buttons_t buttons,
	output logic                         ser_bit
);
	import nes_input_pkg::*;

	// Serial register, bit 0 is the next bit the CPU sees
	logic [BUTTON_COUNT-1:0] shift_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			// Empty pad reads as ones like a disconnected controller
			shift_q <= '1;
		end else if (strobe) begin
			// Parallel load every cycle so reads do not advance
			shift_q <= buttons;
		end else if (shift) begin
			// Move toward bit 0 and fill the top with 1
			// After eight reads only ones remain
			shift_q <= {1'b1, shift_q[BUTTON_COUNT-1:1]};
		end
	end

	// Current bit that the bus port captures on a read
	assign ser_bit = shift_q[0];

	// While strobing the output follows the A button one cycle later
	a_strobe_tracks_a : assert property (
		@(posedge clk) disable iff (!rst)
		strobe |=> ser_bit == $past(buttons.a)
	);

endmodule

`default_nettype wire

// ==== source/button_debounce.sv ====
// Button debouncer for one controller port
// Synchronizes the raw pins and accepts a bit only after it holds steady
`default_nettype none

module button_debounce (
	input  wire                          clk,
	input  wire                          rst,
	input  wire nes_input_pkg::buttons_t pins,
	output nes_input_pkg::buttons_t      buttons
);
	import nes_input_pkg::*;

	// Synchronizer chain, stage 0 samples the asynchronous pins
	logic [SYNC_STAGES-1:0][BUTTON_COUNT-1:0] sync_q;
	logic [BUTTON_COUNT-1:0]                  sync_bits;

	// Accepted button levels
	logic [BUTTON_COUNT-1:0]                  stable_q;

	// One hold counter per button
	logic [BUTTON_COUNT-1:0][DEBOUNCE_W-1:0]  cnt_q;

	// Last stage of the chain is safe to use in the clk domain
	assign sync_bits = sync_q[SYNC_STAGES-1];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], pins};
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt_q    <= '0;
			stable_q <= '0;
		end else begin
			for (int i = 0; i < BUTTON_COUNT; i++) begin
				if (sync_bits[i] == stable_q[i]) begin
					// Nothing pending, or a bounce went back
					cnt_q[i] <= '0;
				end else if (cnt_q[i] == DEBOUNCE_W'(DEBOUNCE_CYCLES)) begin
					// Held long enough
					stable_q[i] <= sync_bits[i];
					cnt_q[i]    <= '0;
				end else begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	// Debounced levels go straight to the shifter
	assign buttons = stable_q;

	// An accepted bit only moves after its counter ran out
	for (genvar g = 0; g < BUTTON_COUNT; g++) begin : g_chk
		a_change_after_hold : assert property (
			@(posedge clk) disable iff (!rst)
			$changed(stable_q[g]) |-> $past(cnt_q[g]) == DEBOUNCE_W'(DEBOUNCE_CYCLES)
		);
	end

endmodule

`default_nettype wire

// ==== source/nes_input_pkg.sv ====
// NES input package
// Controller port addresses, synchronizer and debounce lengths, bus and button types
`default_nettype none

package nes_input_pkg;

	// CPU addresses of the two controller ports
	// Port 0 also holds the strobe latch
	localparam logic [15:0] JOY0_ADDR = 16'h4016;
	localparam logic [15:0] JOY1_ADDR = 16'h4017;

	// Flops in each pin synchronizer
	localparam int SYNC_STAGES = 2;

	// Cycles a synchronized bit must hold before it is accepted
	// Short so simulation stays fast
	localparam int DEBOUNCE_CYCLES = 4;
	localparam int DEBOUNCE_W = 3;

	// Buttons on one standard controller
	localparam int BUTTON_COUNT = 8;

	// CPU side of the bus as one bundle
	// Plain level enables with no handshake
	typedef struct packed {
		logic [15:0] addr;
		logic        read_en;
		logic        write_en;
		logic [7:0]  wdata;
	} cpu_bus_t;

	// One port's buttons, 1 = pressed
	// Bit 0 is A, the first bit the CPU reads
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic start;
		logic select;
		logic b;
		logic a;
	} buttons_t;

endpackage

`default_nettype wire
